/* src/sram_ctrl_pkg.sv */
package sram_ctrl_pkg;

    // External SRAM geometry
    localparam int SRAM_ADDR_WIDTH    = 20;
    localparam int SRAM_DATA_WIDTH    = 16;

    // Requester side
    localparam int BUS_ADDR_WIDTH     = 21;  // Byte address
    localparam int BUS_DATA_WIDTH     = 32;
    localparam int BUS_SEL_WIDTH      = BUS_DATA_WIDTH / 8;

    // Queue entries, also the credits the requester starts with
    localparam int REQ_QUEUE_DEPTH    = 4;
    localparam int QUEUE_PTR_WIDTH    = $clog2(REQ_QUEUE_DEPTH);
    localparam int QUEUE_CNT_WIDTH    = $clog2(REQ_QUEUE_DEPTH + 1);

    // Cycles each halfword phase holds address and strobes
    localparam int ACCESS_WAIT_CYCLES = 2;
    localparam int WAIT_CNT_WIDTH     = $clog2(ACCESS_WAIT_CYCLES + 1);

    typedef logic [SRAM_ADDR_WIDTH-1:0] sram_addr_t;
    typedef logic [SRAM_DATA_WIDTH-1:0] sram_data_t;
    typedef logic [BUS_ADDR_WIDTH-1:0]  bus_addr_t;
    typedef logic [BUS_DATA_WIDTH-1:0]  bus_data_t;
    typedef logic [BUS_SEL_WIDTH-1:0]   bus_sel_t;
    typedef logic [WAIT_CNT_WIDTH-1:0]  wait_cnt_t;

    typedef enum logic [1:0] {
        IDLE,
        PHASE_LO,
        PHASE_HI,
        RETIRE
    } sram_state_t;

endpackage

/* src/sram_req_queue.sv */
module sram_req_queue (
    input  logic                     clk,
    input  logic                     i_reset,

    input  logic                     i_push,
    input  logic                     i_we,
    input  sram_ctrl_pkg::bus_addr_t i_addr,
    input  sram_ctrl_pkg::bus_data_t i_data,
    input  sram_ctrl_pkg::bus_sel_t  i_sel,

    input  logic                     i_pop,
    output logic                     o_empty,
    output logic                     o_head_we,
    output sram_ctrl_pkg::bus_addr_t o_head_addr,
    output sram_ctrl_pkg::bus_data_t o_head_data,
    output sram_ctrl_pkg::bus_sel_t  o_head_sel,

    output logic                     o_credit_return
);

    import sram_ctrl_pkg::*;

    logic                       we_mem   [REQ_QUEUE_DEPTH];
    bus_addr_t                  addr_mem [REQ_QUEUE_DEPTH];
    bus_data_t                  data_mem [REQ_QUEUE_DEPTH];
    bus_sel_t                   sel_mem  [REQ_QUEUE_DEPTH];

    logic [QUEUE_PTR_WIDTH-1:0] wr_ptr;
    logic [QUEUE_PTR_WIDTH-1:0] rd_ptr;
    logic [QUEUE_CNT_WIDTH-1:0] count;
    logic                       full;

    assign o_empty = (count == '0);
    assign full    = (count == QUEUE_CNT_WIDTH'(REQ_QUEUE_DEPTH));

    always_ff @(posedge clk) begin
        if (i_push) begin
            we_mem[wr_ptr]   <= i_we;
            addr_mem[wr_ptr] <= i_addr;
            data_mem[wr_ptr] <= i_data;
            sel_mem[wr_ptr]  <= i_sel;
        end
    end

    // Pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk) begin
        if (i_reset) begin
            wr_ptr          <= '0;
            rd_ptr          <= '0;
            count           <= '0;
            o_credit_return <= 1'b0;
        end else begin
            if (i_push) wr_ptr <= wr_ptr + 1'b1;
            if (i_pop)  rd_ptr <= rd_ptr + 1'b1;
            count           <= count + QUEUE_CNT_WIDTH'(i_push) - QUEUE_CNT_WIDTH'(i_pop);
            o_credit_return <= i_pop;  // Entry freed, credit back
        end
    end

    assign o_head_we   = we_mem[rd_ptr];
    assign o_head_addr = addr_mem[rd_ptr];
    assign o_head_data = data_mem[rd_ptr];
    assign o_head_sel  = sel_mem[rd_ptr];

    // A push into a full queue means the requester spent a credit it did not hold
    a_no_push_full: assert property (@(posedge clk) disable iff (i_reset)
        i_push |-> !full)
        else $error("sram_req_queue: push while full, request without credit");

    a_no_pop_empty: assert property (@(posedge clk) disable iff (i_reset)
        i_pop |-> !o_empty)
        else $error("sram_req_queue: pop while empty");

endmodule

/* src/sram_access_timer.sv */
module sram_access_timer (
    input  logic clk,
    input  logic i_reset,

    input  logic i_start,
    output logic o_busy,
    output logic o_done
);

    import sram_ctrl_pkg::*;

    wait_cnt_t cnt;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            cnt <= '0;
        end else if (i_start) begin
            cnt <= wait_cnt_t'(ACCESS_WAIT_CYCLES);
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
        end
    end

    assign o_busy = (cnt != '0);
    assign o_done = (cnt == wait_cnt_t'(1));  // Last cycle of the phase

    // Back to back phases reload exactly in the done cycle, never earlier
    a_start_not_busy: assert property (@(posedge clk) disable iff (i_reset)
        i_start |-> (!o_busy || o_done))
        else $error("sram_access_timer: start while a phase is still running");

endmodule

/* src/sram_ctrl_fsm.sv */
module sram_ctrl_fsm (
    input  logic                    clk,
    input  logic                    i_reset,

    input  logic                    i_empty,
    input  logic                    i_head_we,
    input  sram_ctrl_pkg::bus_sel_t i_head_sel,
    input  logic                    i_timer_done,

    output logic                    o_timer_start,
    output logic                    o_phase_en,
    output logic                    o_phase_hi,
    output logic                    o_capture,
    output logic                    o_retire,
    output logic                    o_pop
);

    import sram_ctrl_pkg::*;

    sram_state_t state;
    sram_state_t next_state;
    logic        in_phase;
    logic        lo_active;
    logic        hi_active;

    assign lo_active = |i_head_sel[1:0];
    assign hi_active = |i_head_sel[3:2];
    assign in_phase  = (state == PHASE_LO) || (state == PHASE_HI);

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (!i_empty) begin
                    if (lo_active) begin
                        next_state = PHASE_LO;
                    end else if (hi_active) begin
                        next_state = PHASE_HI;
                    end else begin
                        next_state = RETIRE;  // Nothing selected
                    end
                end
            end
            PHASE_LO: begin
                if (i_timer_done) begin
                    next_state = hi_active ? PHASE_HI : RETIRE;
                end
            end
            PHASE_HI: begin
                if (i_timer_done) begin
                    next_state = RETIRE;
                end
            end
            RETIRE: begin
                next_state = IDLE;
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // Phase controls look one state ahead of the registered pins
    assign o_phase_en    = (next_state == PHASE_LO) || (next_state == PHASE_HI);
    assign o_phase_hi    = (next_state == PHASE_HI);
    assign o_timer_start = o_phase_en && (next_state != state);

    assign o_capture     = in_phase && i_timer_done && !i_head_we;  // Read data settled
    assign o_pop         = (state == RETIRE);
    assign o_retire      = (state == RETIRE) && !i_head_we;

    // A busy FSM always works on the queue head
    a_head_present: assert property (@(posedge clk) disable iff (i_reset)
        (state != IDLE) |-> !i_empty)
        else $error("sram_ctrl_fsm: active state with an empty queue");

endmodule

/* src/sram_datapath.sv */
module sram_datapath (
    input  logic                      clk,
    input  logic                      i_reset,

    // Head request
    input  logic                      i_we,
    input  sram_ctrl_pkg::bus_addr_t  i_addr,
    input  sram_ctrl_pkg::bus_data_t  i_data,
    input  sram_ctrl_pkg::bus_sel_t   i_sel,

    // Controls from the FSM
    input  logic                      i_phase_en,
    input  logic                      i_phase_hi,
    input  logic                      i_capture,
    input  logic                      i_retire,

    // SRAM pins
    input  sram_ctrl_pkg::sram_data_t i_sram_dq,
    output sram_ctrl_pkg::sram_addr_t o_sram_addr,
    output sram_ctrl_pkg::sram_data_t o_sram_dq,
    output logic                      o_sram_ce_n,
    output logic                      o_sram_oe_n,
    output logic                      o_sram_we_n,
    output logic                      o_sram_ub_n,
    output logic                      o_sram_lb_n,

    // Read response
    output logic                      o_rsp_valid,
    output sram_ctrl_pkg::bus_data_t  o_rsp_data
);

    import sram_ctrl_pkg::*;

    bus_data_t  rd_asm;
    sram_data_t wr_half;
    logic       sel_lb;
    logic       sel_ub;
    logic       cur_hi;

    // Lane selects of the phase about to be driven
    assign wr_half = i_phase_hi ? i_data[31:16] : i_data[15:0];
    assign sel_lb  = i_phase_hi ? i_sel[2] : i_sel[0];
    assign sel_ub  = i_phase_hi ? i_sel[3] : i_sel[1];

    // Phase bit is the halfword address LSB
    assign cur_hi  = o_sram_addr[0];

    always_ff @(posedge clk) begin
        if (i_phase_en) begin
            o_sram_addr <= {i_addr[BUS_ADDR_WIDTH-1:2], i_phase_hi};
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_sram_ce_n <= 1'b1;
            o_sram_oe_n <= 1'b1;
            o_sram_we_n <= 1'b1;
            o_sram_ub_n <= 1'b1;
            o_sram_lb_n <= 1'b1;
            o_sram_dq   <= '0;
        end else begin
            o_sram_ce_n <= !i_phase_en;
            o_sram_oe_n <= !(i_phase_en && !i_we);
            o_sram_we_n <= !(i_phase_en && i_we);
            o_sram_ub_n <= !(i_phase_en && sel_ub);
            o_sram_lb_n <= !(i_phase_en && sel_lb);
            o_sram_dq   <= (i_phase_en && i_we) ? wr_half : '0;  // Bus quiet unless writing
        end
    end

    // Unselected bytes read back as zero
    always_ff @(posedge clk) begin
        if (i_reset) begin
            rd_asm <= '0;
        end else if (i_retire) begin
            rd_asm <= '0;  // Next read starts clean
        end else if (i_capture) begin
            if (cur_hi) begin
                rd_asm[23:16] <= i_sel[2] ? i_sram_dq[7:0]  : 8'h00;
                rd_asm[31:24] <= i_sel[3] ? i_sram_dq[15:8] : 8'h00;
            end else begin
                rd_asm[7:0]   <= i_sel[0] ? i_sram_dq[7:0]  : 8'h00;
                rd_asm[15:8]  <= i_sel[1] ? i_sram_dq[15:8] : 8'h00;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_rsp_valid <= 1'b0;
        end else begin
            o_rsp_valid <= i_retire;
        end
    end

    always_ff @(posedge clk) begin
        if (i_retire) begin
            o_rsp_data <= rd_asm;
        end
    end

endmodule

/* src/sram_subsys_top.sv */
module sram_subsys_top (
    input  logic                      clk,
    input  logic                      i_reset,

    // Requester, credit based
    input  logic                      i_req_valid,
    input  logic                      i_req_we,
    input  sram_ctrl_pkg::bus_addr_t  i_req_addr,
    input  sram_ctrl_pkg::bus_data_t  i_req_data,
    input  sram_ctrl_pkg::bus_sel_t   i_req_sel,
    output logic                      o_credit_return,
    output logic                      o_rsp_valid,
    output sram_ctrl_pkg::bus_data_t  o_rsp_data,

    // SRAM, data bus split into in and out
    input  sram_ctrl_pkg::sram_data_t i_sram_dq,
    output sram_ctrl_pkg::sram_addr_t o_sram_addr,
    output sram_ctrl_pkg::sram_data_t o_sram_dq,
    output logic                      o_sram_ce_n,
    output logic                      o_sram_oe_n,
    output logic                      o_sram_we_n,
    output logic                      o_sram_ub_n,
    output logic                      o_sram_lb_n
);

    import sram_ctrl_pkg::*;

    logic      q_empty;
    logic      head_we;
    bus_addr_t head_addr;
    bus_data_t head_data;
    bus_sel_t  head_sel;
    logic      pop;
    logic      timer_start;
    logic      timer_done;
    logic      phase_en;
    logic      phase_hi;
    logic      capture;
    logic      retire;

    sram_req_queue sram_req_queue_inst (
        .clk             (clk),
        .i_reset         (i_reset),
        .i_push          (i_req_valid),
        .i_we            (i_req_we),
        .i_addr          (i_req_addr),
        .i_data          (i_req_data),
        .i_sel           (i_req_sel),
        .i_pop           (pop),
        .o_empty         (q_empty),
        .o_head_we       (head_we),
        .o_head_addr     (head_addr),
        .o_head_data     (head_data),
        .o_head_sel      (head_sel),
        .o_credit_return (o_credit_return)
    );

    sram_access_timer sram_access_timer_inst (
        .clk     (clk),
        .i_reset (i_reset),
        .i_start (timer_start),
        .o_busy  (),
        .o_done  (timer_done)
    );

    sram_ctrl_fsm sram_ctrl_fsm_inst (
        .clk           (clk),
        .i_reset       (i_reset),
        .i_empty       (q_empty),
        .i_head_we     (head_we),
        .i_head_sel    (head_sel),
        .i_timer_done  (timer_done),
        .o_timer_start (timer_start),
        .o_phase_en    (phase_en),
        .o_phase_hi    (phase_hi),
        .o_capture     (capture),
        .o_retire      (retire),
        .o_pop         (pop)
    );

    sram_datapath sram_datapath_inst (
        .clk         (clk),
        .i_reset     (i_reset),
        .i_we        (head_we),
        .i_addr      (head_addr),
        .i_data      (head_data),
        .i_sel       (head_sel),
        .i_phase_en  (phase_en),
        .i_phase_hi  (phase_hi),
        .i_capture   (capture),
        .i_retire    (retire),
        .i_sram_dq   (i_sram_dq),
        .o_sram_addr (o_sram_addr),
        .o_sram_dq   (o_sram_dq),
        .o_sram_ce_n (o_sram_ce_n),
        .o_sram_oe_n (o_sram_oe_n),
        .o_sram_we_n (o_sram_we_n),
        .o_sram_ub_n (o_sram_ub_n),
        .o_sram_lb_n (o_sram_lb_n),
        .o_rsp_valid (o_rsp_valid),
        .o_rsp_data  (o_rsp_data)
    );

endmodule

/* dv/sram_model.sv */
module sram_model (
    input  logic                      clk,
    input  sram_ctrl_pkg::sram_addr_t i_addr,
    input  sram_ctrl_pkg::sram_data_t i_dq,
    output sram_ctrl_pkg::sram_data_t o_dq,
    input  logic                      i_ce_n,
    input  logic                      i_oe_n,
    input  logic                      i_we_n,
    input  logic                      i_ub_n,
    input  logic                      i_lb_n
);

    timeunit 1ns;
    timeprecision 1ns;

    import sram_ctrl_pkg::*;

    sram_data_t mem [1 << SRAM_ADDR_WIDTH];

    initial begin
        for (int i = 0; i < (1 << SRAM_ADDR_WIDTH); i++) begin
            mem[i] <= '0;  // Unwritten cells read as zero
        end
    end

    // Strobes are held over the whole phase, rewriting the same lanes is harmless
    always @(posedge clk) begin
        if (!i_ce_n && !i_we_n) begin
            if (!i_lb_n) mem[i_addr][7:0]  <= i_dq[7:0];
            if (!i_ub_n) mem[i_addr][15:8] <= i_dq[15:8];
        end
    end

    assign o_dq = (!i_ce_n && !i_oe_n)
                ? {(i_ub_n ? 8'h00 : mem[i_addr][15:8]), (i_lb_n ? 8'h00 : mem[i_addr][7:0])}
                : '0;  // Quiet lanes read zero

endmodule

/* dv/tb_sram_subsys.sv */
module tb_sram_subsys;

    timeunit 1ns;
    timeprecision 1ns;

    import sram_ctrl_pkg::*;

    localparam int WAIT_LIMIT = 200;  // Cycles

    logic       clk = 1'b0;
    logic       reset;
    logic       req_valid;
    logic       req_we;
    bus_addr_t  req_addr;
    bus_data_t  req_data;
    bus_sel_t   req_sel;
    logic       credit_return;
    logic       rsp_valid;
    bus_data_t  rsp_data;
    sram_addr_t sram_addr;
    sram_data_t sram_rd_dq;
    sram_data_t sram_wr_dq;
    logic       sram_ce_n;
    logic       sram_oe_n;
    logic       sram_we_n;
    logic       sram_ub_n;
    logic       sram_lb_n;

    // One queue per table column
    string      t_name [$];
    logic       t_we   [$];
    bus_addr_t  t_addr [$];
    bus_data_t  t_data [$];
    bus_sel_t   t_sel  [$];

    string      exp_name [$];
    bus_data_t  exp_data [$];
    bus_data_t  ref_mem  [1 << (BUS_ADDR_WIDTH - 2)];  // One word per word index

    int         credits;
    int         issued;
    int         returned;
    int         checks;
    int         errors;
    logic       timed_out;
    integer     seed = 95;

    sram_subsys_top uut (
        .clk             (clk),
        .i_reset         (reset),
        .i_req_valid     (req_valid),
        .i_req_we        (req_we),
        .i_req_addr      (req_addr),
        .i_req_data      (req_data),
        .i_req_sel       (req_sel),
        .o_credit_return (credit_return),
        .o_rsp_valid     (rsp_valid),
        .o_rsp_data      (rsp_data),
        .i_sram_dq       (sram_rd_dq),
        .o_sram_addr     (sram_addr),
        .o_sram_dq       (sram_wr_dq),
        .o_sram_ce_n     (sram_ce_n),
        .o_sram_oe_n     (sram_oe_n),
        .o_sram_we_n     (sram_we_n),
        .o_sram_ub_n     (sram_ub_n),
        .o_sram_lb_n     (sram_lb_n)
    );

    sram_model sram_model_inst (
        .clk    (clk),
        .i_addr (sram_addr),
        .i_dq   (sram_wr_dq),
        .o_dq   (sram_rd_dq),
        .i_ce_n (sram_ce_n),
        .i_oe_n (sram_oe_n),
        .i_we_n (sram_we_n),
        .i_ub_n (sram_ub_n),
        .i_lb_n (sram_lb_n)
    );

    always #50 clk = ~clk;

    task automatic add_entry(input string name, input logic we, input bus_addr_t addr,
                             input bus_data_t data, input bus_sel_t sel);
        t_name.push_back(name);
        t_we.push_back(we);
        t_addr.push_back(addr);
        t_data.push_back(data);
        t_sel.push_back(sel);
    endtask

    task automatic check_value(input string name, input bus_data_t expected,
                               input bus_data_t actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("%s", what);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out waiting for %s", what);
        errors++;
        timed_out = 1'b1;
    endtask

    // Packed as ce oe we ub lb rsp credit
    task automatic check_idle_pins(input string tag);
        check_value(tag, bus_data_t'(7'b1111100),
                    bus_data_t'({sram_ce_n, sram_oe_n, sram_we_n, sram_ub_n, sram_lb_n,
                                 rsp_valid, credit_return}));
    endtask

    // Outputs are registered, so the falling edge sees them settled
    task automatic tick();
        @(negedge clk);
        if (!reset) begin
            if (credit_return) begin
                credits++;
                returned++;
                check_true(credits <= REQ_QUEUE_DEPTH, "Credit returned with no request outstanding");
            end
            if (rsp_valid) begin
                if (exp_data.size() == 0) begin
                    check_true(1'b0, "Read response arrived with no read outstanding");
                end else begin
                    check_value(exp_name.pop_front(), exp_data.pop_front(), rsp_data);
                end
            end
            if (sram_we_n) check_value("dq_idle", '0, bus_data_t'(sram_wr_dq));
        end
    endtask

    task automatic drive_idle();
        req_valid = 1'b0;
        req_we    = 1'b0;
        req_addr  = '0;
        req_data  = '0;
        req_sel   = '0;
    endtask

    task automatic wait_for_credit();
        int waited;
        waited = 0;
        while (credits == 0 && !timed_out) begin
            if (waited >= WAIT_LIMIT) begin
                report_timeout("a returned credit");
            end else begin
                tick();
                waited++;
            end
        end
    endtask

    task automatic issue_entry(input int idx);
        bus_data_t word;
        int        widx;
        widx      = int'(t_addr[idx][BUS_ADDR_WIDTH-1:2]);
        word      = ref_mem[widx];
        req_valid = 1'b1;
        req_we    = t_we[idx];
        req_addr  = t_addr[idx];
        req_data  = t_data[idx];
        req_sel   = t_sel[idx];
        credits--;
        issued++;
        if (t_we[idx]) begin
            for (int b = 0; b < BUS_SEL_WIDTH; b++) begin
                if (t_sel[idx][b]) word[8*b +: 8] = t_data[idx][8*b +: 8];
            end
            ref_mem[widx] = word;
        end else begin
            for (int b = 0; b < BUS_SEL_WIDTH; b++) begin
                if (!t_sel[idx][b]) word[8*b +: 8] = 8'h00;  // Unselected byte reads zero
            end
            exp_name.push_back(t_name[idx]);
            exp_data.push_back(word);
        end
        tick();
        drive_idle();
    endtask

    task automatic apply_entries(input int first, input int last);
        for (int i = first; i < last; i++) begin
            wait_for_credit();
            if (!timed_out) issue_entry(i);
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while ((credits != REQ_QUEUE_DEPTH || exp_data.size() != 0) && !timed_out) begin
            if (waited >= WAIT_LIMIT) begin
                report_timeout("all requests to retire");
            end else begin
                tick();
                waited++;
            end
        end
    endtask

    // Word index maps to the halfword pair {index, 0} and {index, 1}
    task automatic compare_memory();
        int        widx;
        bus_data_t stored;
        for (int i = 0; i < t_name.size(); i++) begin
            widx   = int'(t_addr[i][BUS_ADDR_WIDTH-1:2]);
            stored = {sram_model_inst.mem[2 * widx + 1], sram_model_inst.mem[2 * widx]};
            check_value({"mem_", t_name[i]}, ref_mem[widx], stored);
        end
    endtask

    initial begin
        int          first_partial;
        int          first_burst;
        int          first_random;
        logic [31:0] rnd;

        reset     = 1'b1;
        drive_idle();
        credits   = REQ_QUEUE_DEPTH;
        issued    = 0;
        returned  = 0;
        checks    = 0;
        errors    = 0;
        timed_out = 1'b0;
        for (int i = 0; i < (1 << (BUS_ADDR_WIDTH - 2)); i++) begin
            ref_mem[i] = '0;
        end

        add_entry("wr_full",        1'b1, 21'h000100, 32'hdeadbeef, 4'b1111);
        add_entry("rd_full",        1'b0, 21'h000100, 32'h00000000, 4'b1111);
        first_partial = t_name.size();
        add_entry("wr_base",        1'b1, 21'h000200, 32'h11223344, 4'b1111);
        add_entry("wr_byte1",       1'b1, 21'h000200, 32'h00005500, 4'b0010);
        add_entry("wr_hi_half",     1'b1, 21'h000200, 32'hcafe0000, 4'b1100);
        add_entry("rd_merged",      1'b0, 21'h000200, 32'h00000000, 4'b1111);
        add_entry("wr_byte0_new",   1'b1, 21'h000204, 32'h000000a5, 4'b0001);
        add_entry("rd_byte0_new",   1'b0, 21'h000204, 32'h00000000, 4'b1111);
        add_entry("rd_lo_only",     1'b0, 21'h000200, 32'h00000000, 4'b0011);
        add_entry("rd_hi_only",     1'b0, 21'h000200, 32'h00000000, 4'b1100);
        add_entry("rd_no_sel",      1'b0, 21'h000200, 32'h00000000, 4'b0000);
        add_entry("wr_no_sel",      1'b1, 21'h000200, 32'hffffffff, 4'b0000);
        add_entry("rd_after_nosel", 1'b0, 21'h000200, 32'h00000000, 4'b1111);
        first_burst = t_name.size();
        add_entry("burst_wr0",      1'b1, 21'h000300, 32'h01020304, 4'b1111);
        add_entry("burst_wr1",      1'b1, 21'h000304, 32'h05060708, 4'b1111);
        add_entry("burst_rd0",      1'b0, 21'h000300, 32'h00000000, 4'b1111);
        add_entry("burst_rd1",      1'b0, 21'h000304, 32'h00000000, 4'b1111);
        add_entry("burst_rd_fifth", 1'b0, 21'h000300, 32'h00000000, 4'b1111);
        first_random = t_name.size();
        for (int i = 0; i < 24; i++) begin
            rnd = $random(seed);  // Sixteen words so reads hit earlier writes
            add_entry($sformatf("rand_%0d", i), rnd[0],
                      bus_addr_t'(32'h400 + {26'd0, rnd[4:1], 2'b00}), $random(seed), rnd[8:5]);
        end

        tick();
        for (int c = 0; c < 8; c++) begin
            tick();
            check_idle_pins("reset_idle");
        end
        reset = 1'b0;
        tick();
        check_idle_pins("after_reset_idle");

        apply_entries(0, first_partial);
        drain();
        apply_entries(first_partial, first_burst);
        drain();
        apply_entries(first_burst, first_burst + REQ_QUEUE_DEPTH);
        check_value("burst_credits", '0, bus_data_t'(credits));
        apply_entries(first_burst + REQ_QUEUE_DEPTH, first_random);
        apply_entries(first_random, t_name.size());
        drain();
        for (int i = 0; i < 10; i++) begin
            tick();  // Catch stray credits or responses
        end
        check_value("credits_returned", bus_data_t'(issued), bus_data_t'(returned));
        check_value("credits_held", bus_data_t'(REQ_QUEUE_DEPTH), bus_data_t'(credits));
        compare_memory();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* sim.f */
src/sram_ctrl_pkg.sv
src/sram_req_queue.sv
src/sram_access_timer.sv
src/sram_ctrl_fsm.sv
src/sram_datapath.sv
src/sram_subsys_top.sv
dv/sram_model.sv
dv/tb_sram_subsys.sv

/* Bender.yml */
package:
  name: sram_subsys

sources:
  - src/sram_ctrl_pkg.sv
  - src/sram_req_queue.sv
  - src/sram_access_timer.sv
  - src/sram_ctrl_fsm.sv
  - src/sram_datapath.sv
  - src/sram_subsys_top.sv
  - target: test
    files:
      - dv/sram_model.sv
      - dv/tb_sram_subsys.sv
